/* sim.f */
+incdir+hw
+incdir+verification
hw/riscv_isa_pkg.sv
hw/bru_pipe_pkg.sv
hw/bru_issue_if.sv
hw/bru_issue_queue.sv
hw/bru_decoder.sv
hw/bru_phys_regfile.sv
hw/bru_pipe.sv
hw/bru_top.sv
verification/tb_bru_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the branch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wall -f sim.f --top-module tb_bru_top -o tb_bru_top

./obj_dir/tb_bru_top > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

/* verification/tb_bru_tests.svh */
// Branch unit directed tests

task automatic test_reset_state();
  int e0;
  e0 = errors;
  check_val("o_upd_valid", 32'(o_upd_valid), 32'd0);
  check_val("o_link_valid", 32'(o_link_valid), 32'd0);
  check_val("o_issue_ready", 32'(o_issue_ready), 32'd1);
  report_test("reset state", e0);
endtask

task automatic test_cond_branches();
  logic [2:0]  f3s [6];
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] pc;
  int          e0;
  e0  = errors;
  f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  for (int i = 0; i < 6; i++) begin
    for (int v = 0; v < 4; v++) begin
      a = $urandom();
      b = (v == 2) ? a : $urandom();
      if (v == 0) begin  // Sign boundary
        a = 32'h8000_0000;
        b = 32'h7fff_ffff;
      end
      if (v == 3) a = 32'hffff_ffff;
      wb_write(5'd1, a);
      wb_write(5'd2, b);
      pc = {$urandom() & 32'h000f_fffc};
      send(enc_branch(f3s[i], 13'h1ff8), pc, 5'd1, 5'd2, 5'd0, 1'b0, 32'd0);
      expect_branch(pc, f3s[i], a, b, 13'h1ff8, 1'b0, 32'd0);
    end
  end
  report_test("conditional branches", e0);
endtask

task automatic test_jumps();
  int e0;
  e0 = errors;
  send(enc_jal(21'h800), 32'h1000, 5'd0, 5'd0, 5'd5, 1'b1, 32'h1800);
  expect_jump(32'h1000, 32'h1800, 5'd5, 1'b1, 32'h1800);
  send(enc_jal(21'h1f_fff0), 32'h1100, 5'd0, 5'd0, 5'd0, 1'b0, 32'd0);
  expect_jump(32'h1100, 32'h10f0, 5'd0, 1'b0, 32'd0);
  wb_write(5'd3, 32'h2001);
  send(enc_jalr(12'h010), 32'h1200, 5'd3, 5'd0, 5'd4, 1'b1, 32'h2010);
  expect_jump(32'h1200, 32'h2010, 5'd4, 1'b1, 32'h2010);
  send(enc_jalr(12'hffc), 32'h1300, 5'd3, 5'd0, 5'd0, 1'b1, 32'h0);
  expect_jump(32'h1300, 32'h1ffc, 5'd0, 1'b1, 32'h0);
  report_test("jumps and link", e0);
endtask

task automatic test_forwarding();
  int e0;
  e0 = errors;
  wb_write(5'd6, 32'h11);
  wb_write(5'd7, 32'h22);
  // Write-back during ex0
  send(enc_branch(3'b000, 13'h20), 32'h5000, 5'd6, 5'd7, 5'd0, 1'b0, 32'd0);
  wb_write(5'd6, 32'h22);
  expect_branch(32'h5000, 3'b000, reg_value(5'd6), reg_value(5'd7), 13'h20, 1'b0, 32'd0);
  // Write-back during ex1
  send(enc_branch(3'b001, 13'h20), 32'h5100, 5'd6, 5'd7, 5'd0, 1'b1, 32'h5120);
  @(posedge i_clk);
  #1;
  wb_write(5'd7, 32'h33);
  expect_branch(32'h5100, 3'b001, reg_value(5'd6), reg_value(5'd7), 13'h20, 1'b1, 32'h5120);
  // Branch on a preceding JAL's link register
  wb_write(5'd9, 32'h5204);
  send(enc_jal(21'h40), 32'h5200, 5'd0, 5'd0, 5'd8, 1'b1, 32'h5240);
  send(enc_branch(3'b000, 13'h10), 32'h5240, 5'd8, 5'd9, 5'd0, 1'b1, 32'h5250);
  expect_jump(32'h5200, 32'h5240, 5'd8, 1'b1, 32'h5240);
  expect_branch(32'h5240, 3'b000, reg_value(5'd8), 32'h5204, 13'h10, 1'b1, 32'h5250);
  // Tag 0 ignores a write-back of the other operand's value
  send(enc_branch(3'b000, 13'h8), 32'h5300, 5'd0, 5'd6, 5'd0, 1'b0, 32'd0);
  wb_write(5'd0, reg_value(5'd6));
  expect_branch(32'h5300, 3'b000, 32'd0, reg_value(5'd6), 13'h8, 1'b0, 32'd0);
  report_test("forwarding", e0);
endtask

task automatic test_stream();
  int e0;
  e0 = errors;
  for (int i = 0; i < 6; i++) begin
    send(enc_branch(3'b001, 13'h40), 32'h6000 + 32'(i * 4), 5'd0, 5'd0, 5'd0, 1'b0, 32'd0);
  end
  for (int i = 0; i < 6; i++) begin
    expect_branch(32'h6000 + 32'(i * 4), 3'b001, 32'd0, 32'd0, 13'h40, 1'b0, 32'd0);
  end
  repeat (4) @(posedge i_clk);
  #1;
  check_val("outcomes left over", 32'(upd_pc_q.size()), 32'd0);
  report_test("back-to-back stream", e0);
endtask

task automatic test_flush();
  int e0;
  e0          = errors;
  stalls      = 0;
  flush_ready = 1'b1;
  send(enc_branch(3'b000, 13'h40), 32'h3000, 5'd0, 5'd0, 5'd0, 1'b0, 32'd0);
  send(enc_jal(21'h100), 32'h3004, 5'd0, 5'd0, 5'd9, 1'b1, 32'h3104);
  send(enc_branch(3'b001, 13'h40), 32'h3008, 5'd0, 5'd0, 5'd0, 1'b0, 32'd0);
  send(enc_branch(3'b001, 13'h40), 32'h300c, 5'd0, 5'd0, 5'd0, 1'b0, 32'd0);
  expect_branch(32'h3000, 3'b000, 32'd0, 32'd0, 13'h40, 1'b0, 32'd0);
  // Last one waited out the flush cycle and survives
  expect_branch(32'h300c, 3'b001, 32'd0, 32'd0, 13'h40, 1'b0, 32'd0);
  check_val("o_issue_ready in flush", 32'(flush_ready), 32'd0);
  check_val("issue stalls", 32'(stalls), 32'd1);
  send(enc_branch(3'b001, 13'h40), 32'h4000, 5'd0, 5'd0, 5'd0, 1'b0, 32'd0);
  expect_branch(32'h4000, 3'b001, 32'd0, 32'd0, 13'h40, 1'b0, 32'd0);
  repeat (6) @(posedge i_clk);
  #1;
  check_val("outcomes left over", 32'(upd_pc_q.size()), 32'd0);
  report_test("mispredict flush", e0);
endtask

/* verification/tb_bru_top.sv */
// Branch unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_bru_top;

  logic        i_clk;
  logic        i_reset_n;
  logic        i_issue_valid;
  logic        o_issue_ready;
  logic [31:0] i_issue_inst;
  logic [31:0] i_issue_pc;
  logic [4:0]  i_issue_rs1;
  logic [4:0]  i_issue_rs2;
  logic [4:0]  i_issue_rd;
  logic        i_issue_pred_taken;
  logic [31:0] i_issue_pred_target;
  logic        i_wb_valid;
  logic [4:0]  i_wb_rnid;
  logic [31:0] i_wb_data;
  logic        o_upd_valid;
  logic [31:0] o_upd_pc;
  logic        o_upd_taken;
  logic        o_upd_mispredict;
  logic [31:0] o_upd_target;
  logic        o_link_valid;
  logic [4:0]  o_link_rnid;
  logic [31:0] o_link_data;

  // Outcomes in arrival order
  logic [31:0] upd_pc_q[$];
  logic        upd_taken_q[$];
  logic        upd_mis_q[$];
  logic [31:0] upd_tgt_q[$];
  logic        link_v_q[$];
  logic [4:0]  link_rnid_q[$];
  logic [31:0] link_data_q[$];

  logic [31:0] model_regs [32];
  logic        flush_ready;  // Ready seen during the last flush cycle
  int          checks;
  int          errors;
  int          stalls;

  bru_top dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // --------------------
  // Outcome monitor
  // --------------------
  always @(negedge i_clk) begin
    if (i_reset_n && o_upd_valid) begin
      upd_pc_q.push_back(o_upd_pc);
      upd_taken_q.push_back(o_upd_taken);
      upd_mis_q.push_back(o_upd_mispredict);
      upd_tgt_q.push_back(o_upd_target);
      link_v_q.push_back(o_link_valid);
      link_rnid_q.push_back(o_link_rnid);
      link_data_q.push_back(o_link_data);
      if (o_upd_mispredict) flush_ready = o_issue_ready;
    end
    assert (!(i_reset_n && o_link_valid && !o_upd_valid)) else begin
      $display("Link write seen without a branch outcome at %0t", $time);
      errors++;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] reg_value(input logic [4:0] tag);
    return (tag == 5'd0) ? 32'd0 : model_regs[tag];
  endfunction

  // Comparison result for a conditional branch funct3
  function automatic logic cmp_taken(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [12:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_jalr(input logic [11:0] imm);
    return {imm, 5'd1, 3'b000, 5'd1, 7'b1100111};
  endfunction

  // Holds valid until accepted, returns 1 ns after the accepting edge
  task automatic send(input logic [31:0] inst, input logic [31:0] pc, input logic [4:0] rs1,
                      input logic [4:0] rs2, input logic [4:0] rd, input logic pt,
                      input logic [31:0] ptgt);
    int  n;
    logic rdy;
    i_issue_valid       = 1'b1;
    i_issue_inst        = inst;
    i_issue_pc          = pc;
    i_issue_rs1         = rs1;
    i_issue_rs2         = rs2;
    i_issue_rd          = rd;
    i_issue_pred_taken  = pt;
    i_issue_pred_target = ptgt;
    n = 0;
    do begin
      rdy = o_issue_ready;
      @(posedge i_clk);
      #1;
      if (!rdy) stalls++;
      n++;
    end while (!rdy && n < 20);
    if (!rdy) begin
      $display("Timeout waiting for the issue port to accept at %0t", $time);
      errors++;
    end
    i_issue_valid = 1'b0;
  endtask

  task automatic wb_write(input logic [4:0] tag, input logic [31:0] data);
    i_wb_valid = 1'b1;
    i_wb_rnid  = tag;
    i_wb_data  = data;
    if (tag != 5'd0) model_regs[tag] = data;
    @(posedge i_clk);
    #1;
    i_wb_valid = 1'b0;
  endtask

  // Waits for the next outcome and compares every field
  task automatic expect_next(input logic [31:0] pc, input logic taken, input logic [31:0] tgt,
                             input logic mis, input logic lv, input logic [4:0] lrn,
                             input logic [31:0] ldata);
    int n;
    n = 0;
    while (upd_pc_q.size() == 0 && n < 20) begin
      @(posedge i_clk);
      #1;
      n++;
    end
    if (upd_pc_q.size() == 0) begin
      $display("Timeout waiting for the outcome of pc %h", pc);
      errors++;
    end else begin
      check_val("o_upd_pc", upd_pc_q.pop_front(), pc);
      check_val("o_upd_taken", 32'(upd_taken_q.pop_front()), 32'(taken));
      check_val("o_upd_target", upd_tgt_q.pop_front(), tgt);
      check_val("o_upd_mispredict", 32'(upd_mis_q.pop_front()), 32'(mis));
      check_val("o_link_valid", 32'(link_v_q.pop_front()), 32'(lv));
      if (lv) begin
        check_val("o_link_rnid", 32'(link_rnid_q.pop_front()), 32'(lrn));
        check_val("o_link_data", link_data_q.pop_front(), ldata);
      end else begin
        void'(link_rnid_q.pop_front());
        void'(link_data_q.pop_front());
      end
    end
  endtask

  // Expected outcome of a conditional branch from model operands
  task automatic expect_branch(input logic [31:0] pc, input logic [2:0] f3,
                               input logic [31:0] a, input logic [31:0] b,
                               input logic [12:0] off, input logic pt,
                               input logic [31:0] ptgt);
    logic        tk;
    logic [31:0] tgt;
    tk  = cmp_taken(f3, a, b);
    tgt = tk ? pc + {{19{off[12]}}, off} : pc + 32'd4;
    expect_next(pc, tk, tgt, (tk != pt) || (tk && pt && tgt != ptgt), 1'b0, 5'd0, 32'd0);
  endtask

  task automatic expect_jump(input logic [31:0] pc, input logic [31:0] tgt,
                             input logic [4:0] rd, input logic pt, input logic [31:0] ptgt);
    expect_next(pc, 1'b1, tgt, !pt || (tgt != ptgt), rd != 5'd0, rd, pc + 32'd4);
    if (rd != 5'd0) model_regs[rd] = pc + 32'd4;
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - err_before);
  endtask

  `include "tb_bru_tests.svh"

  initial begin
    void'($urandom(32'h205e));
    i_reset_n           = 1'b0;
    i_issue_valid       = 1'b0;
    i_issue_inst        = '0;
    i_issue_pc          = '0;
    i_issue_rs1         = '0;
    i_issue_rs2         = '0;
    i_issue_rd          = '0;
    i_issue_pred_taken  = 1'b0;
    i_issue_pred_target = '0;
    i_wb_valid          = 1'b0;
    i_wb_rnid           = '0;
    i_wb_data           = '0;
    flush_ready         = 1'b1;
    checks              = 0;
    errors              = 0;
    stalls              = 0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (16) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    @(posedge i_clk);
    #1;
    test_reset_state();
    test_cond_branches();
    test_jumps();
    test_forwarding();
    test_stream();
    test_flush();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/bru_top.sv */
// Branch execution subsystem
`timescale 1ns/1ps
`default_nettype none
`include "bru_params.svh"

module bru_top (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset_n,
  input  wire logic                  i_issue_valid,
  output logic                       o_issue_ready,
  input  wire riscv_isa_pkg::inst_t  i_issue_inst,
  input  wire riscv_isa_pkg::vaddr_t i_issue_pc,
  input  wire bru_pipe_pkg::rnid_t   i_issue_rs1,
  input  wire bru_pipe_pkg::rnid_t   i_issue_rs2,
  input  wire bru_pipe_pkg::rnid_t   i_issue_rd,
  input  wire logic                  i_issue_pred_taken,
  input  wire riscv_isa_pkg::vaddr_t i_issue_pred_target,
  input  wire logic                  i_wb_valid,
  input  wire bru_pipe_pkg::rnid_t   i_wb_rnid,
  input  wire riscv_isa_pkg::xlen_t  i_wb_data,
  output logic                       o_upd_valid,
  output riscv_isa_pkg::vaddr_t      o_upd_pc,
  output logic                       o_upd_taken,
  output logic                       o_upd_mispredict,
  output riscv_isa_pkg::vaddr_t      o_upd_target,
  output logic                       o_link_valid,
  output bru_pipe_pkg::rnid_t        o_link_rnid,
  output riscv_isa_pkg::xlen_t       o_link_data
);

  bru_pipe_pkg::rnid_t   w_rd_rnid [2];
  riscv_isa_pkg::xlen_t  w_rd_data [2];
  bru_pipe_pkg::phy_wr_t w_tgt_bus [`BRU_TGT_BUS];
  bru_pipe_pkg::phy_wr_t w_link_wr;
  logic                  w_flush;

  bru_issue_if u_issue_if ();

  // Slot 0 external write-back, slot 1 link write
  always_comb begin
    w_tgt_bus[0] = '{valid: i_wb_valid, rd_rnid: i_wb_rnid, rd_data: i_wb_data};
    w_tgt_bus[1] = w_link_wr;
  end

  assign w_flush      = o_upd_valid & o_upd_mispredict;
  assign o_link_valid = w_link_wr.valid;
  assign o_link_rnid  = w_link_wr.rd_rnid;
  assign o_link_data  = w_link_wr.rd_data;

  bru_issue_queue u_queue (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_valid       (i_issue_valid),
    .o_ready       (o_issue_ready),
    .i_inst        (i_issue_inst),
    .i_pc          (i_issue_pc),
    .i_rs1         (i_issue_rs1),
    .i_rs2         (i_issue_rs2),
    .i_rd          (i_issue_rd),
    .i_pred_taken  (i_issue_pred_taken),
    .i_pred_target (i_issue_pred_target),
    .i_flush       (w_flush),
    .issue         (u_issue_if)
  );

  bru_pipe u_pipe (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .issue            (u_issue_if),
    .o_rd_rnid        (w_rd_rnid),
    .i_rd_data        (w_rd_data),
    .i_tgt_bus        (w_tgt_bus),
    .o_link_wr        (w_link_wr),
    .o_upd_valid      (o_upd_valid),
    .o_upd_pc         (o_upd_pc),
    .o_upd_taken      (o_upd_taken),
    .o_upd_mispredict (o_upd_mispredict),
    .o_upd_target     (o_upd_target)
  );

  bru_phys_regfile u_regfile (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_rd_rnid (w_rd_rnid),
    .o_rd_data (w_rd_data),
    .i_wr      (w_tgt_bus)  // Bus doubles as write ports
  );

endmodule

`default_nettype wire

/* hw/bru_pipe.sv */
// Three-stage branch pipeline
`timescale 1ns/1ps
`default_nettype none
`include "bru_params.svh"

module bru_pipe (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset_n,
  bru_issue_if.pipe                  issue,
  output bru_pipe_pkg::rnid_t        o_rd_rnid [2],
  input  wire riscv_isa_pkg::xlen_t  i_rd_data [2],
  input  wire bru_pipe_pkg::phy_wr_t i_tgt_bus [`BRU_TGT_BUS],
  output bru_pipe_pkg::phy_wr_t      o_link_wr,
  output logic                       o_upd_valid,
  output riscv_isa_pkg::vaddr_t      o_upd_pc,
  output logic                       o_upd_taken,
  output logic                       o_upd_mispredict,
  output riscv_isa_pkg::vaddr_t      o_upd_target
);

  bru_pipe_pkg::pipe_ctrl_t w_ex0_ctrl;
  riscv_isa_pkg::xlen_t     w_ex0_rs1;
  riscv_isa_pkg::xlen_t     w_ex0_rs2;
  logic                     w_flush;

  logic                     r_ex1_valid;
  bru_pipe_pkg::pipe_ctrl_t r_ex1_ctrl;
  riscv_isa_pkg::inst_t     r_ex1_inst;
  riscv_isa_pkg::vaddr_t    r_ex1_pc;
  bru_pipe_pkg::rnid_t      r_ex1_rs1_rnid;
  bru_pipe_pkg::rnid_t      r_ex1_rs2_rnid;
  bru_pipe_pkg::rnid_t      r_ex1_rd_rnid;
  logic                     r_ex1_pred_taken;
  riscv_isa_pkg::vaddr_t    r_ex1_pred_target;
  riscv_isa_pkg::xlen_t     r_ex1_rs1_data;
  riscv_isa_pkg::xlen_t     r_ex1_rs2_data;
  riscv_isa_pkg::xlen_t     w_ex1_rs1;
  riscv_isa_pkg::xlen_t     w_ex1_rs2;
  logic                     w_ex1_taken;
  riscv_isa_pkg::vaddr_t    w_ex1_off_sb;
  riscv_isa_pkg::vaddr_t    w_ex1_off_uj;
  riscv_isa_pkg::vaddr_t    w_ex1_off_i;
  riscv_isa_pkg::vaddr_t    w_ex1_pc_next;
  riscv_isa_pkg::vaddr_t    w_ex1_br_tgt;
  riscv_isa_pkg::vaddr_t    w_ex1_target;
  logic                     w_ex1_mispred;

  logic                     r_ex2_valid;
  logic                     r_ex2_wr_rd;
  logic                     r_ex2_taken;
  logic                     r_ex2_mispred;
  riscv_isa_pkg::vaddr_t    r_ex2_pc;
  riscv_isa_pkg::vaddr_t    r_ex2_target;
  bru_pipe_pkg::rnid_t      r_ex2_rd_rnid;

  // Newest matching bus slot overrides the operand
  function automatic riscv_isa_pkg::xlen_t fwd_data(input bru_pipe_pkg::rnid_t  rnid,
                                                    input riscv_isa_pkg::xlen_t base);
    riscv_isa_pkg::xlen_t data;
    data = base;
    for (int t = 0; t < `BRU_TGT_BUS; t++) begin
      if (i_tgt_bus[t].valid && (i_tgt_bus[t].rd_rnid == rnid) && (rnid != '0)) begin
        data = i_tgt_bus[t].rd_data;
      end
    end
    return data;
  endfunction

  // --------------------
  // ex0
  // --------------------
  bru_decoder u_decoder (
    .i_inst (issue.inst),
    .o_ctrl (w_ex0_ctrl)
  );

  always_comb begin
    o_rd_rnid[0] = issue.rs1_rnid;
    o_rd_rnid[1] = issue.rs2_rnid;
    w_ex0_rs1    = fwd_data(issue.rs1_rnid, i_rd_data[0]);
    w_ex0_rs2    = fwd_data(issue.rs2_rnid, i_rd_data[1]);
  end

  assign w_flush = r_ex2_valid & r_ex2_mispred;  // Kills ex0 and ex1

  // --------------------
  // ex1
  // --------------------
  assign w_ex1_off_sb  = {{(`BRU_XLEN-13){r_ex1_inst[31]}}, r_ex1_inst[31], r_ex1_inst[7],
                          r_ex1_inst[30:25], r_ex1_inst[11:8], 1'b0};
  assign w_ex1_off_uj  = {{(`BRU_XLEN-21){r_ex1_inst[31]}}, r_ex1_inst[31], r_ex1_inst[19:12],
                          r_ex1_inst[20], r_ex1_inst[30:21], 1'b0};
  assign w_ex1_off_i   = {{(`BRU_XLEN-12){r_ex1_inst[31]}}, r_ex1_inst[31:20]};
  assign w_ex1_pc_next = r_ex1_pc + riscv_isa_pkg::vaddr_t'(4);

  always_comb begin
    w_ex1_rs1 = fwd_data(r_ex1_rs1_rnid, r_ex1_rs1_data);
    w_ex1_rs2 = fwd_data(r_ex1_rs2_rnid, r_ex1_rs2_data);
    case (r_ex1_ctrl.op)
      riscv_isa_pkg::OP_EQ:   w_ex1_taken = (w_ex1_rs1 == w_ex1_rs2);
      riscv_isa_pkg::OP_NE:   w_ex1_taken = (w_ex1_rs1 != w_ex1_rs2);
      riscv_isa_pkg::OP_LT:   w_ex1_taken = ($signed(w_ex1_rs1) <  $signed(w_ex1_rs2));
      riscv_isa_pkg::OP_GE:   w_ex1_taken = ($signed(w_ex1_rs1) >= $signed(w_ex1_rs2));
      riscv_isa_pkg::OP_LTU:  w_ex1_taken = (w_ex1_rs1 <  w_ex1_rs2);
      riscv_isa_pkg::OP_GEU:  w_ex1_taken = (w_ex1_rs1 >= w_ex1_rs2);
      riscv_isa_pkg::OP_JUMP: w_ex1_taken = 1'b1;
      default:                w_ex1_taken = 1'b0;
    endcase
    case (r_ex1_ctrl.imm)
      riscv_isa_pkg::IMM_SB: w_ex1_br_tgt = r_ex1_pc + w_ex1_off_sb;
      riscv_isa_pkg::IMM_UJ: w_ex1_br_tgt = r_ex1_pc + w_ex1_off_uj;
      // JALR drops bit 0
      riscv_isa_pkg::IMM_I:  w_ex1_br_tgt = (w_ex1_rs1 + w_ex1_off_i) &
                                            ~riscv_isa_pkg::vaddr_t'(1);
      default:               w_ex1_br_tgt = w_ex1_pc_next;
    endcase
    w_ex1_target  = w_ex1_taken ? w_ex1_br_tgt : w_ex1_pc_next;
    w_ex1_mispred = (w_ex1_taken != r_ex1_pred_taken) |
                    (w_ex1_taken & r_ex1_pred_taken & (w_ex1_target != r_ex1_pred_target));
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex1_ctrl  <= '0;
      r_ex2_valid <= 1'b0;
      r_ex2_wr_rd <= 1'b0;
    end else begin
      r_ex1_valid <= issue.valid & ~w_flush;
      r_ex1_ctrl  <= w_ex0_ctrl;
      r_ex2_valid <= r_ex1_valid & ~w_flush;
      r_ex2_wr_rd <= r_ex1_ctrl.wr_rd;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_inst        <= issue.inst;
    r_ex1_pc          <= issue.pc;
    r_ex1_rs1_rnid    <= issue.rs1_rnid;
    r_ex1_rs2_rnid    <= issue.rs2_rnid;
    r_ex1_rd_rnid     <= issue.rd_rnid;
    r_ex1_pred_taken  <= issue.pred_taken;
    r_ex1_pred_target <= issue.pred_target;
    r_ex1_rs1_data    <= w_ex0_rs1;
    r_ex1_rs2_data    <= w_ex0_rs2;
    r_ex2_taken       <= w_ex1_taken;
    r_ex2_mispred     <= w_ex1_mispred;
    r_ex2_pc          <= r_ex1_pc;
    r_ex2_target      <= w_ex1_target;
    r_ex2_rd_rnid     <= r_ex1_rd_rnid;
  end

  // --------------------
  // ex2
  // --------------------
  assign o_upd_valid      = r_ex2_valid;
  assign o_upd_pc         = r_ex2_pc;
  assign o_upd_taken      = r_ex2_taken;
  assign o_upd_mispredict = r_ex2_mispred;
  assign o_upd_target     = r_ex2_target;

  always_comb begin
    o_link_wr.valid   = r_ex2_valid & r_ex2_wr_rd & (r_ex2_rd_rnid != '0);
    o_link_wr.rd_rnid = r_ex2_rd_rnid;
    o_link_wr.rd_data = r_ex2_pc + riscv_isa_pkg::xlen_t'(4);  // Return address
  end

endmodule

`default_nettype wire

/* hw/bru_phys_regfile.sv */
// Physical register file
`timescale 1ns/1ps
`default_nettype none
`include "bru_params.svh"

module bru_phys_regfile (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset_n,
  input  wire bru_pipe_pkg::rnid_t   i_rd_rnid [2],
  output riscv_isa_pkg::xlen_t       o_rd_data [2],
  input  wire bru_pipe_pkg::phy_wr_t i_wr [`BRU_TGT_BUS]
);

  localparam int NUM_REGS = 1 << `BRU_RNID_W;

  riscv_isa_pkg::xlen_t r_regs [NUM_REGS];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        r_regs[i] <= '0;
      end
    end else begin
      // Higher slot wins on same tag
      for (int s = 0; s < `BRU_TGT_BUS; s++) begin
        if (i_wr[s].valid) begin
          r_regs[i_wr[s].rd_rnid] <= i_wr[s].rd_data;
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      o_rd_data[p] = (i_rd_rnid[p] == '0) ? '0 : r_regs[i_rd_rnid[p]];  // Tag 0 is zero
    end
  end

endmodule

`default_nettype wire

/* hw/bru_decoder.sv */
// Branch instruction decoder
`timescale 1ns/1ps
`default_nettype none

module bru_decoder (
  input  wire riscv_isa_pkg::inst_t i_inst,
  output bru_pipe_pkg::pipe_ctrl_t  o_ctrl
);

  logic [2:0] w_funct3;

  assign w_funct3 = i_inst[14:12];

  always_comb begin
    o_ctrl.op    = riscv_isa_pkg::OP_NONE;
    o_ctrl.imm   = riscv_isa_pkg::IMM_NONE;
    o_ctrl.wr_rd = 1'b0;
    case (i_inst[6:0])
      riscv_isa_pkg::OPC_BRANCH: begin
        o_ctrl.imm = riscv_isa_pkg::IMM_SB;
        case (w_funct3)
          3'b000:  o_ctrl.op = riscv_isa_pkg::OP_EQ;
          3'b001:  o_ctrl.op = riscv_isa_pkg::OP_NE;
          3'b100:  o_ctrl.op = riscv_isa_pkg::OP_LT;
          3'b101:  o_ctrl.op = riscv_isa_pkg::OP_GE;
          3'b110:  o_ctrl.op = riscv_isa_pkg::OP_LTU;
          3'b111:  o_ctrl.op = riscv_isa_pkg::OP_GEU;
          default: o_ctrl.imm = riscv_isa_pkg::IMM_NONE;  // Reserved funct3
        endcase
      end
      riscv_isa_pkg::OPC_JAL: begin
        o_ctrl.op    = riscv_isa_pkg::OP_JUMP;
        o_ctrl.imm   = riscv_isa_pkg::IMM_UJ;
        o_ctrl.wr_rd = 1'b1;
      end
      riscv_isa_pkg::OPC_JALR: begin
        if (w_funct3 == 3'b000) begin
          o_ctrl.op    = riscv_isa_pkg::OP_JUMP;
          o_ctrl.imm   = riscv_isa_pkg::IMM_I;
          o_ctrl.wr_rd = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hw/bru_issue_queue.sv */
// Branch instruction queue
`timescale 1ns/1ps
`default_nettype none
`include "bru_params.svh"

module bru_issue_queue (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset_n,
  input  wire logic                  i_valid,
  output logic                       o_ready,
  input  wire riscv_isa_pkg::inst_t  i_inst,
  input  wire riscv_isa_pkg::vaddr_t i_pc,
  input  wire bru_pipe_pkg::rnid_t   i_rs1,
  input  wire bru_pipe_pkg::rnid_t   i_rs2,
  input  wire bru_pipe_pkg::rnid_t   i_rd,
  input  wire logic                  i_pred_taken,
  input  wire riscv_isa_pkg::vaddr_t i_pred_target,
  input  wire logic                  i_flush,
  bru_issue_if.queue                 issue
);

  localparam int PTR_W = $clog2(`BRU_IQ_DEPTH);

  typedef struct packed {
    riscv_isa_pkg::inst_t  inst;
    riscv_isa_pkg::vaddr_t pc;
    bru_pipe_pkg::rnid_t   rs1;
    bru_pipe_pkg::rnid_t   rs2;
    bru_pipe_pkg::rnid_t   rd;
    logic                  pred_taken;
    riscv_isa_pkg::vaddr_t pred_target;
  } entry_t;

  entry_t           r_mem [`BRU_IQ_DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [PTR_W:0]   r_count;
  logic             w_push;
  logic             w_pop;
  entry_t           w_head;

  assign o_ready = (r_count != (PTR_W+1)'(`BRU_IQ_DEPTH)) & ~i_flush;  // Full or flushing
  assign w_push  = i_valid & o_ready;
  assign w_pop   = (r_count != '0);  // Pipe never stalls

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else if (i_flush) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (w_push) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      if (w_pop) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
      r_count <= r_count + {{PTR_W{1'b0}}, w_push} - {{PTR_W{1'b0}}, w_pop};
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_mem[r_wr_ptr] <= '{i_inst, i_pc, i_rs1, i_rs2, i_rd, i_pred_taken, i_pred_target};
    end
  end

  // --------------------
  // Head to ex0
  // --------------------
  assign w_head            = r_mem[r_rd_ptr];
  assign issue.valid       = w_pop;
  assign issue.inst        = w_head.inst;
  assign issue.pc          = w_head.pc;
  assign issue.rs1_rnid    = w_head.rs1;
  assign issue.rs2_rnid    = w_head.rs2;
  assign issue.rd_rnid     = w_head.rd;
  assign issue.pred_taken  = w_head.pred_taken;
  assign issue.pred_target = w_head.pred_target;

endmodule

`default_nettype wire

/* hw/bru_issue_if.sv */
// Branch issue interface
`timescale 1ns/1ps
`default_nettype none

interface bru_issue_if;

  logic                  valid;  // Instruction in ex0 this cycle
  riscv_isa_pkg::inst_t  inst;
  riscv_isa_pkg::vaddr_t pc;
  bru_pipe_pkg::rnid_t   rs1_rnid;
  bru_pipe_pkg::rnid_t   rs2_rnid;
  bru_pipe_pkg::rnid_t   rd_rnid;
  logic                  pred_taken;
  riscv_isa_pkg::vaddr_t pred_target;

  modport queue (
    output valid, inst, pc, rs1_rnid, rs2_rnid, rd_rnid, pred_taken, pred_target
  );

  modport pipe (
    input valid, inst, pc, rs1_rnid, rs2_rnid, rd_rnid, pred_taken, pred_target
  );

endinterface

`default_nettype wire

/* hw/bru_pipe_pkg.sv */
// Branch pipeline types
`default_nettype none
`include "bru_params.svh"

package bru_pipe_pkg;

  // Physical register tag
  typedef logic [`BRU_RNID_W-1:0] rnid_t;

  // --------------------
  // Write bus
  // --------------------
  typedef struct packed {
    logic                 valid;
    rnid_t                rd_rnid;
    riscv_isa_pkg::xlen_t rd_data;
  } phy_wr_t;

  // --------------------
  // Decoded control
  // --------------------
  typedef struct packed {
    riscv_isa_pkg::bru_op_e op;
    riscv_isa_pkg::imm_e    imm;
    logic                   wr_rd;  // Writes the link register
  } pipe_ctrl_t;

endpackage

`default_nettype wire

/* hw/riscv_isa_pkg.sv */
// RISC-V ISA types
`default_nettype none
`include "bru_params.svh"

package riscv_isa_pkg;

  typedef logic [`BRU_XLEN-1:0] xlen_t;
  typedef logic [`BRU_XLEN-1:0] vaddr_t;  // Virtual address
  typedef logic [31:0]          inst_t;

  // Major opcodes handled by the branch unit
  typedef enum logic [6:0] {
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    OP_EQ,
    OP_NE,
    OP_LT,
    OP_GE,
    OP_LTU,
    OP_GEU,
    OP_JUMP,
    OP_NONE
  } bru_op_e;

  typedef enum logic [1:0] {
    IMM_SB,
    IMM_UJ,
    IMM_I,
    IMM_NONE
  } imm_e;

endpackage

`default_nettype wire

/* hw/bru_params.svh */
// Branch unit parameters
`ifndef BRU_PARAMS_SVH
`define BRU_PARAMS_SVH

// --------------------
// Datapath
// --------------------
`define BRU_XLEN      32  // Data and address width
`define BRU_RNID_W    5   // 32 physical registers

// --------------------
// Structure
// --------------------
// Queue depth must be a power of two
`define BRU_IQ_DEPTH  4
`define BRU_TGT_BUS   2   // Write-back and link write

`endif
